/* uart_bridge_pkg.sv */
// Shared types, ASCII constants and parameter defaults for the UART to AXI-Lite bridge
package uart_bridge_pkg;

    // ==================================================
    // Parameter defaults
    // ==================================================
    localparam int DEF_CLK_HZ         = 100_000_000;
    localparam int DEF_BAUD_RATE      = 115200;
    localparam int DEF_INIT_WAIT_BITS = 27;     // Power-up wait is 2**N - 1 clocks

    // ==================================================
    // Bus types
    // ==================================================
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } cmd_kind_e;

    // Request from the parser to the bus master
    typedef struct packed {
        cmd_kind_e kind;
        addr_t     addr;
        data_t     data;    // Zero for reads
    } bus_cmd_t;

    // Master toward slave
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        data_t wdata;
        logic  arvalid;
        addr_t araddr;
    } axi_req_t;

    // Slave toward master, bready and rready are implied high
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        logic  arready;
        logic  rvalid;
        data_t rdata;
    } axi_rsp_t;

    // ASCII characters of the command protocol
    localparam logic [7:0] CHAR_CR    = 8'h0D;
    localparam logic [7:0] CHAR_LF    = 8'h0A;
    localparam logic [7:0] CHAR_SPACE = 8'h20;
    localparam logic [7:0] CHAR_QUERY = 8'h3F;

endpackage

/* uart_rx.sv */
// Serial 8-N-1 receiver, presents each received byte with a one-cycle strobe
`timescale 1ns/10ps

module uart_rx import uart_bridge_pkg::*; #(
    parameter int CLK_HZ    = DEF_CLK_HZ,
    parameter int BAUD_RATE = DEF_BAUD_RATE
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       rx_i,
    output logic       byte_stb_o,
    output logic [7:0] byte_o
);
    localparam int CLKS_PER_BIT = CLK_HZ / BAUD_RATE;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int STOP_TICKS   = CLKS_PER_BIT + HALF_BIT;   // Mid bit 7 to end of stop
    localparam int CNT_W        = $clog2(STOP_TICKS + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             rx_meta;
    logic             rx_sync;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk_i) begin
        rx_meta <= rx_i;
        rx_sync <= rx_meta;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= RX_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            byte_stb_o <= 1'b0;
        end else begin
            byte_stb_o <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= RX_START;   // Falling edge of start bit
                end
                RX_START: begin
                    if (clk_cnt == CNT_W'(HALF_BIT - 1)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;   // Glitch rejected
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        shift   <= {rx_sync, shift[7:1]};   // LSB first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    // Leaves at the close of the stop bit
                    if (clk_cnt == CNT_W'(STOP_TICKS - 2)) begin
                        byte_stb_o <= 1'b1;
                        byte_o     <= shift;
                        state      <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* uart_tx.sv */
// Serial 8-N-1 transmitter, sends one byte per strobe and flags busy while shifting
`timescale 1ns/10ps

module uart_tx import uart_bridge_pkg::*; #(
    parameter int CLK_HZ    = DEF_CLK_HZ,
    parameter int BAUD_RATE = DEF_BAUD_RATE
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       stb_i,
    input  logic [7:0] byte_i,
    output logic       tx_o,
    output logic       busy_o
);
    localparam int CLKS_PER_BIT = CLK_HZ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);

    logic [9:0]       shift;    // Stop, data, start
    logic [3:0]       bits_left;
    logic [CNT_W-1:0] clk_cnt;

    assign busy_o = (bits_left != 4'd0);
    assign tx_o   = shift[0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            shift     <= '1;     // Line idles high
            bits_left <= 4'd0;
            clk_cnt   <= '0;
        end else if (!busy_o) begin
            if (stb_i) begin
                shift     <= {1'b1, byte_i, 1'b0};
                bits_left <= 4'd10;
                clk_cnt   <= '0;
            end
        end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            // Next bit, ones fill in behind
            shift     <= {1'b1, shift[9:1]};
            bits_left <= bits_left - 1'b1;
            clk_cnt   <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

/* cmd_parser.sv */
// ASCII command-line parser, turns W/R lines into bus requests and ? into status strobes
`timescale 1ns/10ps

module cmd_parser import uart_bridge_pkg::*; #(
    parameter int INIT_WAIT_BITS = DEF_INIT_WAIT_BITS
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       byte_stb_i,
    input  logic [7:0] byte_i,
    output logic       cmd_stb_o,
    output bus_cmd_t   cmd_o,
    output logic       status_stb_o,
    output logic       status_ready_o
);
    typedef enum logic [1:0] {
        P_IDLE,
        P_ADDR,
        P_DATA
    } parse_state_e;

    parse_state_e              state;
    logic [31:0]               acc;         // Last eight hex digits
    logic                      have_digit;
    logic [INIT_WAIT_BITS-1:0] init_cnt;
    logic                      init_done;
    logic                      is_hex;
    logic [3:0]                nib;
    logic                      is_eol;

    // ==================================================
    // Power-up wait
    // ==================================================
    assign init_done      = &init_cnt;
    assign status_ready_o = init_done;

    always_ff @(posedge clk_i) begin
        if (rst_i) init_cnt <= '0;
        else if (!init_done) init_cnt <= init_cnt + 1'b1;
    end

    // ==================================================
    // Character decode
    // ==================================================
    always_comb begin
        is_hex = 1'b1;
        nib    = 4'd0;
        if (byte_i >= "0" && byte_i <= "9") nib = 4'(byte_i - "0");
        else if (byte_i >= "a" && byte_i <= "f") nib = 4'(byte_i - "a" + 8'd10);
        else if (byte_i >= "A" && byte_i <= "F") nib = 4'(byte_i - "A" + 8'd10);
        else is_hex = 1'b0;
    end

    assign is_eol = (byte_i == CHAR_CR) || (byte_i == CHAR_LF);

    // ==================================================
    // Line FSM
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state        <= P_IDLE;
            have_digit   <= 1'b0;
            cmd_stb_o    <= 1'b0;
            status_stb_o <= 1'b0;
        end else begin
            cmd_stb_o    <= 1'b0;
            status_stb_o <= 1'b0;
            if (byte_stb_i) begin
                case (state)
                    P_IDLE: begin
                        acc        <= '0;
                        have_digit <= 1'b0;
                        if (byte_i == "W" || byte_i == "w") begin
                            cmd_o.kind <= CMD_WRITE;
                            state      <= P_ADDR;
                        end else if (byte_i == "R" || byte_i == "r") begin
                            cmd_o.kind <= CMD_READ;
                            state      <= P_ADDR;
                        end else if (byte_i == CHAR_QUERY) begin
                            status_stb_o <= 1'b1;
                        end
                    end
                    P_ADDR: begin
                        if (is_hex) begin
                            acc        <= {acc[27:0], nib};
                            have_digit <= 1'b1;
                        end else if (byte_i == CHAR_SPACE && have_digit &&
                                     cmd_o.kind == CMD_WRITE) begin
                            cmd_o.addr <= acc;
                            acc        <= '0;
                            state      <= P_DATA;
                        end else if (is_eol && cmd_o.kind == CMD_READ) begin
                            cmd_o.addr <= acc;
                            cmd_o.data <= '0;
                            cmd_stb_o  <= init_done;   // Dropped during power-up wait
                            state      <= P_IDLE;
                        end else begin
                            state <= P_IDLE;           // Bad line, dropped silently
                        end
                    end
                    P_DATA: begin
                        if (is_hex) begin
                            acc <= {acc[27:0], nib};
                        end else if (is_eol) begin
                            cmd_o.data <= acc;
                            cmd_stb_o  <= init_done;
                            state      <= P_IDLE;
                        end else begin
                            state <= P_IDLE;
                        end
                    end
                    default: state <= P_IDLE;
                endcase
            end
        end
    end

endmodule

/* axi_lite_master.sv */
// Single-beat AXI-Lite master, runs one write or read per accepted command
`timescale 1ns/10ps

module axi_lite_master import uart_bridge_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     cmd_stb_i,
    input  bus_cmd_t cmd_i,
    output axi_req_t axi_o,
    input  axi_rsp_t axi_i,
    output logic     rd_stb_o,
    output data_t    rd_data_o
);
    typedef enum logic [2:0] {
        M_IDLE,
        M_WR_AD,    // Address and data channels open
        M_WR_B,
        M_RD_A,
        M_RD_R
    } master_state_e;

    master_state_e state;
    logic          aw_done;
    logic          w_done;

    // A channel is finished once its valid is low or its handshake happens now
    assign aw_done = !axi_o.awvalid || axi_i.awready;
    assign w_done  = !axi_o.wvalid  || axi_i.wready;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state         <= M_IDLE;
            axi_o.awvalid <= 1'b0;
            axi_o.wvalid  <= 1'b0;
            axi_o.arvalid <= 1'b0;
            rd_stb_o      <= 1'b0;
        end else begin
            rd_stb_o <= 1'b0;
            case (state)
                M_IDLE: begin
                    // Commands arriving in any other state are lost
                    if (cmd_stb_i) begin
                        if (cmd_i.kind == CMD_WRITE) begin
                            axi_o.awaddr  <= cmd_i.addr;
                            axi_o.wdata   <= cmd_i.data;
                            axi_o.awvalid <= 1'b1;
                            axi_o.wvalid  <= 1'b1;
                            state         <= M_WR_AD;
                        end else begin
                            axi_o.araddr  <= cmd_i.addr;
                            axi_o.arvalid <= 1'b1;
                            state         <= M_RD_A;
                        end
                    end
                end
                M_WR_AD: begin
                    if (axi_i.awready) axi_o.awvalid <= 1'b0;
                    if (axi_i.wready) axi_o.wvalid <= 1'b0;
                    if (aw_done && w_done) state <= M_WR_B;
                end
                M_WR_B: begin
                    if (axi_i.bvalid) state <= M_IDLE;
                end
                M_RD_A: begin
                    if (axi_i.arready) begin
                        axi_o.arvalid <= 1'b0;
                        state         <= M_RD_R;
                    end
                end
                M_RD_R: begin
                    if (axi_i.rvalid) begin
                        rd_data_o <= axi_i.rdata;
                        rd_stb_o  <= 1'b1;
                        state     <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

endmodule

/* reply_formatter.sv */
// Reply formatter, queues status and read replies and feeds them as ASCII bytes to the UART
`timescale 1ns/10ps

module reply_formatter import uart_bridge_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       rd_stb_i,
    input  data_t      rd_data_i,
    input  logic       status_stb_i,
    input  logic       status_ready_i,
    input  logic       tx_busy_i,
    output logic       tx_stb_o,
    output logic [7:0] tx_byte_o
);
    logic       pend_status;
    logic [7:0] pend_letter;
    logic       pend_rd;
    data_t      pend_word;

    logic       active;       // A reply is being sent
    logic       mode_status;
    logic [7:0] letter;
    data_t      out_word;     // Shifts left one nibble per digit
    logic [3:0] byte_idx;
    logic       last_byte;
    logic [7:0] next_byte;

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10) return 8'h30 + {4'd0, n};
        return 8'h57 + {4'd0, n};    // 'a' for ten
    endfunction

    assign last_byte = mode_status ? (byte_idx == 4'd1) : (byte_idx == 4'd8);

    always_comb begin
        if (last_byte) next_byte = CHAR_LF;
        else if (mode_status) next_byte = letter;
        else next_byte = hex_char(out_word[31:28]);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_status <= 1'b0;
            pend_rd     <= 1'b0;
            active      <= 1'b0;
            byte_idx    <= 4'd0;
            tx_stb_o    <= 1'b0;
        end else begin
            tx_stb_o <= 1'b0;

            if (!active) begin
                if (pend_status) begin
                    // Status goes ahead of a waiting read word
                    active      <= 1'b1;
                    mode_status <= 1'b1;
                    letter      <= pend_letter;
                    byte_idx    <= 4'd0;
                    pend_status <= 1'b0;
                end else if (pend_rd) begin
                    active      <= 1'b1;
                    mode_status <= 1'b0;
                    out_word    <= pend_word;
                    byte_idx    <= 4'd0;
                    pend_rd     <= 1'b0;
                end
            end else if (!tx_busy_i && !tx_stb_o) begin
                tx_stb_o  <= 1'b1;
                tx_byte_o <= next_byte;
                out_word  <= {out_word[27:0], 4'd0};
                byte_idx  <= byte_idx + 1'b1;
                if (last_byte) active <= 1'b0;
            end

            // New requests win over a same-cycle clear
            if (status_stb_i) begin
                pend_status <= 1'b1;
                pend_letter <= status_ready_i ? "R" : "W";
            end
            if (rd_stb_i) begin
                pend_rd   <= 1'b1;
                pend_word <= rd_data_i;   // Replaces a word not yet started
            end
        end
    end

endmodule

/* uart_axi_bridge.sv */
// Top level of the UART to AXI-Lite debug bridge, chains receiver, parser, master, formatter, transmitter
`timescale 1ns/10ps

module uart_axi_bridge import uart_bridge_pkg::*; #(
    parameter int CLK_HZ         = DEF_CLK_HZ,
    parameter int BAUD_RATE      = DEF_BAUD_RATE,
    parameter int INIT_WAIT_BITS = DEF_INIT_WAIT_BITS
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     uart_rx_i,
    output logic     uart_tx_o,
    output axi_req_t axi_o,
    input  axi_rsp_t axi_i
);
    logic       rx_stb;
    logic [7:0] rx_byte;
    logic       cmd_stb;
    bus_cmd_t   bus_cmd;
    logic       status_stb;
    logic       status_ready;
    logic       rd_stb;
    data_t      rd_data;
    logic       tx_stb;
    logic [7:0] tx_byte;
    logic       tx_busy;

    uart_rx #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) uart_rx_i0 (
        .clk_i, .rst_i,
        .rx_i       (uart_rx_i),
        .byte_stb_o (rx_stb),
        .byte_o     (rx_byte)
    );

    cmd_parser #(.INIT_WAIT_BITS(INIT_WAIT_BITS)) cmd_parser_i (
        .clk_i, .rst_i,
        .byte_stb_i     (rx_stb),
        .byte_i         (rx_byte),
        .cmd_stb_o      (cmd_stb),
        .cmd_o          (bus_cmd),
        .status_stb_o   (status_stb),
        .status_ready_o (status_ready)
    );

    axi_lite_master axi_lite_master_i (
        .clk_i, .rst_i,
        .cmd_stb_i (cmd_stb),
        .cmd_i     (bus_cmd),
        .axi_o, .axi_i,
        .rd_stb_o  (rd_stb),
        .rd_data_o (rd_data)
    );

    reply_formatter reply_formatter_i (
        .clk_i, .rst_i,
        .rd_stb_i       (rd_stb),
        .rd_data_i      (rd_data),
        .status_stb_i   (status_stb),
        .status_ready_i (status_ready),
        .tx_busy_i      (tx_busy),
        .tx_stb_o       (tx_stb),
        .tx_byte_o      (tx_byte)
    );

    uart_tx #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) uart_tx_i0 (
        .clk_i, .rst_i,
        .stb_i  (tx_stb),
        .byte_i (tx_byte),
        .tx_o   (uart_tx_o),
        .busy_o (tx_busy)
    );

endmodule

/* tb_uart_axi_bridge.sv */
// Testbench top that sends command lines to the bridge and checks its replies and bus traffic
`timescale 1ns/10ps

module tb_uart_axi_bridge import uart_bridge_pkg::*; ();

    localparam int CLK_HZ     = 1_000_000;
    localparam int BAUD_RATE  = 125_000;
    localparam int WAIT_BITS  = 10;
    localparam int BIT_CLKS   = CLK_HZ / BAUD_RATE;   // Eight clocks per bit
    localparam int PWR_CYCLES = 2 ** WAIT_BITS;
    localparam int TIMEOUT    = 4000;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     rx_line = 1'b1;       // Host to bridge line that idles high
    logic     tx_line;
    axi_req_t axi_req;
    axi_rsp_t axi_rsp = '0;

    integer seed = 32'h418b;
    integer slv_seed = 32'h418b;
    int     err_cnt = 0;
    int     test_errs = 0;
    int     pass_tests = 0;
    int     fail_tests = 0;
    int     cyc = 0;                // Clocks since reset release

    logic [7:0]  rx_q[$];           // Bytes decoded from the bridge output
    int          mon_cnt = -1;
    logic [7:0]  mon_byte;

    logic [31:0] slv_mem [0:255];
    logic [31:0] model_mem [0:255];
    int          wr_count = 0;
    int          rd_count = 0;
    logic [31:0] last_awaddr;
    logic [31:0] last_wdata;
    logic [31:0] last_araddr;
    logic        aw_seen = 1'b0;
    logic        w_seen = 1'b0;
    logic        ar_seen = 1'b0;
    int          aw_wait = 0;
    int          w_wait = 0;
    int          b_wait = 0;
    int          ar_wait = 0;
    int          r_wait = 0;

    always #10 clk = ~clk;

    uart_axi_bridge #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE), .INIT_WAIT_BITS(WAIT_BITS))
        uart_axi_bridge_i (.clk_i(clk), .rst_i(rst), .uart_rx_i(rx_line), .uart_tx_o(tx_line),
                           .axi_o(axi_req), .axi_i(axi_rsp));

    always @(posedge clk) begin
        if (rst) cyc <= 0;
        else cyc <= cyc + 1;
    end

    // ==================================================
    // Checks and helpers
    // ==================================================
    task automatic compare(input logic [31:0] exp, input logic [31:0] act, input string what);
        if (exp !== act) begin
            $display("error at %0d ns: %s, expected %h, got %h", $time, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic report_test(input string name);
        if (err_cnt == test_errs) begin
            pass_tests++;
            $display("test %s: passed", name);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d errors", name, err_cnt - test_errs);
        end
        test_errs = err_cnt;
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5a, 8'hc3 + idx[7:0]};
    endfunction

    function automatic int pick_delay();
        return $unsigned($random(slv_seed)) % 6;
    endfunction

    // ==================================================
    // Serial driver and monitor
    // ==================================================
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};    // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx_line = frame[i];
            repeat (BIT_CLKS - 1) @(negedge clk);
        end
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) send_byte(s[i]);
    endtask

    task automatic send_line(input string s);
        send_text(s);
        send_byte(CHAR_CR);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            mon_cnt = -1;
        end else if (mon_cnt < 0) begin
            if (tx_line === 1'b0) mon_cnt = 0;      // Start bit seen
        end else begin
            mon_cnt = mon_cnt + 1;
            // Mid-bit samples where the start bit falls out of the shift register
            if (mon_cnt % BIT_CLKS == BIT_CLKS / 2 - 1 && mon_cnt < 9 * BIT_CLKS)
                mon_byte = {tx_line, mon_byte[7:1]};
            if (mon_cnt == 9 * BIT_CLKS + BIT_CLKS / 2 - 1) begin
                compare(1, tx_line, "stop bit on the serial output");
                rx_q.push_back(mon_byte);
                mon_cnt = -1;
            end
        end
    end

    task automatic next_reply_byte(output logic [7:0] b);
        int t = 0;
        while (rx_q.size() == 0) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) abort_run("no reply byte from the bridge within the time limit");
        end
        b = rx_q.pop_front();
    endtask

    task automatic expect_word(input logic [31:0] word, input string what);
        string      digits;
        logic [7:0] b;
        digits = $sformatf("%h", word);     // Eight lower-case digits, leading zeros kept
        for (int i = 0; i < 8; i++) begin
            next_reply_byte(b);
            compare(digits[i], b, what);
        end
        next_reply_byte(b);
        compare(CHAR_LF, b, {what, " terminator"});
    endtask

    task automatic expect_status(input logic [7:0] letter);
        logic [7:0] b;
        next_reply_byte(b);
        compare(letter, b, "status letter");
        next_reply_byte(b);
        compare(CHAR_LF, b, "status terminator");
    endtask

    // ==================================================
    // AXI-Lite slave with random delays
    // ==================================================
    task automatic count_down(input logic armed, inout int dly, output logic fire);
        fire = 1'b0;
        if (armed) begin
            if (dly == 0) begin
                fire = 1'b1;
                dly = pick_delay();
            end else begin
                dly--;
            end
        end
    endtask

    always @(negedge clk) begin
        axi_rsp = '0;
        if (rst) begin
            aw_seen = 1'b0;
            w_seen = 1'b0;
            ar_seen = 1'b0;
        end else begin
            // Responses only follow handshakes of earlier cycles
            count_down(aw_seen && w_seen, b_wait, axi_rsp.bvalid);
            if (axi_rsp.bvalid) begin
                slv_mem[last_awaddr[9:2]] = last_wdata;
                wr_count++;
                aw_seen = 1'b0;
                w_seen = 1'b0;
            end
            count_down(ar_seen, r_wait, axi_rsp.rvalid);
            if (axi_rsp.rvalid) begin
                axi_rsp.rdata = slv_mem[last_araddr[9:2]];
                rd_count++;
                ar_seen = 1'b0;
            end
            count_down(axi_req.awvalid && !aw_seen, aw_wait, axi_rsp.awready);
            if (axi_rsp.awready) begin
                aw_seen = 1'b1;
                last_awaddr = axi_req.awaddr;
            end
            count_down(axi_req.wvalid && !w_seen, w_wait, axi_rsp.wready);
            if (axi_rsp.wready) begin
                w_seen = 1'b1;
                last_wdata = axi_req.wdata;
            end
            count_down(axi_req.arvalid && !ar_seen, ar_wait, axi_rsp.arready);
            if (axi_rsp.arready) begin
                ar_seen = 1'b1;
                last_araddr = axi_req.araddr;
            end
        end
    end

    task automatic wait_bus(input int wr_target, input int rd_target);
        int t = 0;
        while (wr_count < wr_target || rd_count < rd_target) begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) abort_run("the AXI-Lite slave saw no completed access in time");
        end
    endtask

    task automatic bus_write(input string line, input logic [31:0] addr, input logic [31:0] data);
        int target;
        target = wr_count + 1;
        send_line(line);
        wait_bus(target, rd_count);
        compare(addr, last_awaddr, "write address");
        compare(data, last_wdata, "write data");
        compare(target, wr_count, "write count");
        model_mem[addr[9:2]] = data;
    endtask

    task automatic bus_read(input string line, input logic [31:0] addr);
        int target;
        target = rd_count + 1;
        send_line(line);
        expect_word(model_mem[addr[9:2]], "read data");
        compare(target, rd_count, "read count");
        compare(addr, last_araddr, "read address");
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        logic [31:0] addrs [0:7];
        logic [31:0] word;
        int          wr_before;
        for (int i = 0; i < 256; i++) begin
            slv_mem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Accesses sent early must be dropped by the power-up wait
        send_text("?");
        send_line("W1 5");
        send_line("R1");
        expect_status("W");
        for (int t = 0; cyc < PWR_CYCLES; t++) begin
            if (t > TIMEOUT) abort_run("the power-up wait did not end within the time limit");
            @(negedge clk);
        end
        compare(0, wr_count, "writes during power-up wait");
        compare(0, rd_count, "reads during power-up wait");
        report_test("power-up wait blocks accesses");

        send_text("?");
        expect_status("R");
        report_test("status ready after power-up");

        for (int i = 0; i < 8; i++) begin
            addrs[i] = $random(seed);
            word = $random(seed);
            bus_write($sformatf("W%h %h", addrs[i], word), addrs[i], word);
        end
        for (int i = 7; i >= 0; i--) bus_read($sformatf("R%h", addrs[i]), addrs[i]);
        report_test("random writes and reads");

        bus_write("w00aBcD10 DeadBeef", 32'h00ab_cd10, 32'hdead_beef);
        bus_write("wFfFf00000A4c 1234aBcD", 32'h0000_0a4c, 32'h1234_abcd);   // Last eight digits
        bus_read("r9900AbCd10", 32'h00ab_cd10);
        bus_read("rA4c", 32'h0000_0a4c);
        bus_write("W7 0F", 32'h0000_0007, 32'h0000_000f);
        bus_read("R7", 32'h0000_0007);
        report_test("case and address length");

        wr_before = wr_count;
        send_line("W12G4 5");
        bus_write("W30 77", 32'h0000_0030, 32'h0000_0077);
        bus_read("R30", 32'h0000_0030);
        compare(wr_before + 1, wr_count, "writes after a broken line");
        report_test("broken line dropped");

        // Status query lands while the read reply is on the wire
        send_line("R30");
        for (int t = 0; mon_cnt < 0; t++) begin
            if (t > TIMEOUT) abort_run("the read reply did not start within the time limit");
            @(negedge clk);
        end
        send_text("?");
        expect_word(model_mem[8'h0c], "read data before status");
        expect_status("R");
        report_test("status queued behind read reply");

        $display("tests passed: %0d, failed: %0d, errors: %0d", pass_tests, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* compile.f */
uart_bridge_pkg.sv
uart_rx.sv
uart_tx.sv
cmd_parser.sv
axi_lite_master.sv
reply_formatter.sv
uart_axi_bridge.sv
tb_uart_axi_bridge.sv
